// ==== sources.f ====
logic/scan_pkg.sv
logic/stream_context.sv
logic/keyword_dfa.sv
logic/match_accum.sv
logic/scan_regs.sv
logic/keyword_scan_top.sv
test/tb_clock.sv
test/keyword_scan_chk.sv
test/keyword_scan_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run, the exit status is the verdict
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f sources.f \
       --top-module keyword_scan_tb -o keyword_scan_sim \
  && ./obj_dir/keyword_scan_sim \
  || exit 1

// ==== test/keyword_scan_tb.sv ====
module keyword_scan_tb;

  localparam int NUM_DIRECTED   = 16;
  localparam int NUM_RANDOM     = 200;
  localparam int MAX_LEN        = 16;
  // Idle beats after each eop, covers the 3 cycle writeback turnaround
  localparam int GAP            = 4;
  localparam int DRAIN          = 4;
  localparam int TIMEOUT_CYCLES = 40 * (NUM_DIRECTED + NUM_RANDOM) + 2000;

  logic                 clk;
  logic                 rst_n;
  scan_pkg::byte_beat_t beat_in;
  scan_pkg::apb_req_t   apb_req;
  scan_pkg::apb_rsp_t   apb_rsp;

  // Expected response of the APB access in flight
  scan_pkg::apb_data_t  exp_rdata;
  logic                 exp_slverr;

  // Reference model, states kept as 0..5 since a full match folds back to 1
  int                   model_state [scan_pkg::NUM_STREAMS];
  logic [63:0]          model_mask;
  scan_pkg::count_t     model_hits;
  scan_pkg::count_t     model_pkts;
  scan_pkg::byte_t      pkt_data [MAX_LEN];
  logic [31:0]          lcg_state;

  tb_clock i_tb_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  keyword_scan_top i_keyword_scan_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .beat_in (beat_in),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
               $time, name, got, expected);
      $display("Some tests failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic string reg_name(input scan_pkg::apb_addr_t addr);
    case (addr)
      scan_pkg::REG_ENABLE_LO: return "ENABLE_LO";
      scan_pkg::REG_ENABLE_HI: return "ENABLE_HI";
      scan_pkg::REG_HIT_COUNT: return "HIT_COUNT";
      scan_pkg::REG_PKT_COUNT: return "PKT_COUNT";
      default:                 return "unmapped";
    endcase
  endfunction

  // Only the four register offsets answer without an error
  function automatic logic bad_offset(input scan_pkg::apb_addr_t addr);
    return !(addr == scan_pkg::REG_ENABLE_LO || addr == scan_pkg::REG_ENABLE_HI ||
             addr == scan_pkg::REG_HIT_COUNT || addr == scan_pkg::REG_PKT_COUNT);
  endfunction

  function automatic scan_pkg::byte_t keyword_char(input int k);
    case (k)
      0:       return "t";
      1:       return "e";
      2:       return "l";
      3:       return "n";
      4:       return "e";
      default: return "t";
    endcase
  endfunction

  // Extend the match or fall back, a stray "t" restarts at 1
  function automatic int model_step(input int st, input scan_pkg::byte_t ch);
    if (ch == keyword_char(st))
    begin
      return st + 1;
    end
    else if (ch == "t")
    begin
      return 1;
    end
    return 0;
  endfunction

  // Runs one packet through the model, returns whether it counts as a hit
  function automatic logic model_packet(input scan_pkg::stream_id_t sid,
                                        input logic new_stream, input int len);
    int   st;
    logic hit;
    st  = new_stream ? 0 : model_state[sid];
    hit = 1'b0;
    for (int i = 0; i < len; i++)
    begin
      st = model_step(st, pkt_data[i]);
      if (st == scan_pkg::KEYWORD_LEN)
      begin
        hit = 1'b1;
        st  = 1;
      end
    end
    model_pkts = model_pkts + 32'd1;
    // Disabled streams keep their old state and never count
    if (model_mask[sid])
    begin
      model_state[sid] = st;
      if (hit)
      begin
        model_hits = model_hits + 32'd1;
      end
    end
    return hit && model_mask[sid];
  endfunction

  function automatic scan_pkg::byte_t pick_char(input int k);
    case (k)
      0:       return "t";
      1:       return "e";
      2:       return "l";
      3:       return "n";
      4:       return "x";
      default: return " ";
    endcase
  endfunction

  function automatic void place_text(input string s, input int off);
    for (int i = 0; i < s.len(); i++)
    begin
      pkt_data[off + i] = s[i];
    end
  endfunction

  // Setup phase, access phase, then release the bus
  task automatic apb_access(input logic write, input scan_pkg::apb_addr_t addr,
                            input scan_pkg::apb_data_t data);
    @(posedge clk);
    apb_req    <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
    exp_rdata  <= data;
    exp_slverr <= bad_offset(addr);
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input scan_pkg::apb_addr_t addr, input scan_pkg::apb_data_t data);
    apb_access(1'b1, addr, data);
  endtask

  // Data here is the value the compare process expects on prdata
  task automatic apb_read(input scan_pkg::apb_addr_t addr, input scan_pkg::apb_data_t expected);
    apb_access(1'b0, addr, expected);
  endtask

  task automatic set_mask(input logic [63:0] mask);
    apb_write(scan_pkg::REG_ENABLE_LO, mask[31:0]);
    apb_write(scan_pkg::REG_ENABLE_HI, mask[63:32]);
    model_mask = mask;
  endtask

  task automatic send_packet(input scan_pkg::stream_id_t sid, input logic new_stream,
                             input int len);
    for (int i = 0; i < len; i++)
    begin
      @(posedge clk);
      beat_in <= '{valid: 1'b1, sop: (i == 0), eop: (i == len - 1),
                   new_stream: new_stream, stream_id: sid, data: pkt_data[i]};
    end
    repeat (GAP)
    begin
      @(posedge clk);
      beat_in <= '0;
    end
  endtask

  // Directed packet, the model outcome is held against the hand-worked one
  task automatic send_text(input scan_pkg::stream_id_t sid, input logic new_stream,
                           input string s, input logic exp_hit);
    logic hit;
    place_text(s, 0);
    hit = model_packet(sid, new_stream, s.len());
    check_value({"hit for ", s}, 32'(hit), 32'(exp_hit));
    send_packet(sid, new_stream, s.len());
  endtask

  task automatic send_random_packet();
    logic [31:0]          r;
    logic [31:0]          r2;
    logic [63:0]          mask;
    scan_pkg::stream_id_t sid;
    logic                 new_stream;
    int                   len;
    r  = lcg_next();
    r2 = lcg_next();
    // 16 streams spread over both halves of the mask
    sid        = scan_pkg::stream_id_t'({r[21:18], 2'b01});
    len        = 1 + int'(r[31:22] % 10'd12);
    new_stream = (r2[31:28] == 4'd0);
    if (r2[15:13] == 3'd0)
    begin
      // Mostly enabled masks
      mask[31:0]  = lcg_next() | lcg_next();
      mask[63:32] = lcg_next() | lcg_next();
      set_mask(mask);
    end
    for (int i = 0; i < len; i++)
    begin
      pkt_data[i] = pick_char(int'((lcg_next() >> 16) % 32'd6));
    end
    // Full keyword, a leading part at the end, or a trailing part at the start
    if (r2[27:25] == 3'd0 && len >= 6)
    begin
      place_text("telnet", int'(r2[24:16]) % (len - 5));
    end
    else if (r2[27:25] == 3'd1 && len >= 3)
    begin
      place_text("tel", len - 3);
    end
    else if (r2[27:25] == 3'd2 && len >= 3)
    begin
      place_text("net", 0);
    end
    void'(model_packet(sid, new_stream, len));
    send_packet(sid, new_stream, len);
  endtask

  task automatic check_counters();
    repeat (DRAIN)
    begin
      @(posedge clk);
      beat_in <= '0;
    end
    apb_read(scan_pkg::REG_HIT_COUNT, model_hits);
    apb_read(scan_pkg::REG_PKT_COUNT, model_pkts);
  endtask

  // Compare process, samples every APB access phase on its completing edge
  always @(posedge clk)
  begin
    if (rst_n && apb_req.psel && apb_req.penable)
    begin
      check_value("pready", 32'(apb_rsp.pready), 32'd1);
      check_value("pslverr", 32'(apb_rsp.pslverr), 32'(exp_slverr));
      if (!apb_req.pwrite && !exp_slverr)
      begin
        check_value({"prdata ", reg_name(apb_req.paddr)}, apb_rsp.prdata, exp_rdata);
      end
    end
  end

  // Watchdog
  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    beat_in    = '0;
    apb_req    = '0;
    exp_rdata  = '0;
    exp_slverr = 1'b0;
    model_mask = '0;
    model_hits = '0;
    model_pkts = '0;
    lcg_state  = 32'd35;
    for (int i = 0; i < scan_pkg::NUM_STREAMS; i++)
    begin
      model_state[i] = 0;
    end
    for (int i = 0; i < MAX_LEN; i++)
    begin
      pkt_data[i] = '0;
    end
    wait (rst_n);

    // Reset values, mask readback, unmapped offsets
    apb_read(scan_pkg::REG_ENABLE_LO, '0);
    apb_read(scan_pkg::REG_ENABLE_HI, '0);
    apb_read(scan_pkg::REG_HIT_COUNT, '0);
    apb_read(scan_pkg::REG_PKT_COUNT, '0);
    set_mask(64'hA5A5_0F0F_1234_5678);
    apb_read(scan_pkg::REG_ENABLE_LO, 32'h1234_5678);
    apb_read(scan_pkg::REG_ENABLE_HI, 32'hA5A5_0F0F);
    apb_read(4'h2, '0);
    apb_write(4'h6, 32'hFFFF_FFFF);
    apb_read(4'hE, '0);
    // Error write leaves the mask alone
    apb_read(scan_pkg::REG_ENABLE_LO, 32'h1234_5678);

    // One hit per packet however many matches
    set_mask('1);
    send_text(6'd3, 1'b1, "xtelnetx", 1'b1);
    send_text(6'd4, 1'b1, "telnetelnet", 1'b1);
    check_counters();

    // Keyword split over two packets of one stream
    send_text(6'd5, 1'b1, "a tel", 1'b0);
    send_text(6'd5, 1'b0, "net ", 1'b1);
    send_text(6'd6, 1'b1, "tel", 1'b0);
    send_text(6'd6, 1'b1, "net", 1'b0);
    // One-byte packet carries a state too
    send_text(6'd10, 1'b1, "t", 1'b0);
    send_text(6'd10, 1'b0, "elnet", 1'b1);
    check_counters();

    // Stream 7 saved "tel" before disabling, stream 9 starts while disabled
    send_text(6'd7, 1'b1, "tel", 1'b0);
    set_mask(~((64'd1 << 7) | (64'd1 << 9)));
    send_text(6'd7, 1'b0, "telnet", 1'b0);
    send_text(6'd9, 1'b1, "tel", 1'b0);
    set_mask('1);
    send_text(6'd7, 1'b0, "net", 1'b1);
    send_text(6'd9, 1'b0, "net", 1'b0);
    check_counters();

    // Clear on write, counting resumes afterwards
    apb_write(scan_pkg::REG_HIT_COUNT, 32'h5A5A_5A5A);
    apb_write(scan_pkg::REG_PKT_COUNT, 32'h5A5A_5A5A);
    model_hits = '0;
    model_pkts = '0;
    check_counters();
    send_text(6'd11, 1'b1, "telnet", 1'b1);
    check_counters();

    // Random run
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      send_random_packet();
    end
    check_counters();

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== test/keyword_scan_chk.sv ====
module keyword_scan_chk (
  input logic                 clk,
  input logic                 rst_n,
  input scan_pkg::apb_req_t   apb_req,
  input scan_pkg::apb_rsp_t   apb_rsp,
  input scan_pkg::dfa_beat_t  dfa_beat,
  input scan_pkg::writeback_t writeback,
  input logic                 pkt_done,
  input logic                 pkt_hit
);

  // Error response only inside an access phase
  slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
    else $error("pslverr raised outside an APB access phase");

  // A hit is always a packet end as well
  hit_is_done: assert property (@(posedge clk) disable iff (!rst_n)
    pkt_hit |-> pkt_done)
    else $error("pkt_hit pulsed without pkt_done");

  // Writeback comes one cycle after the eop beat leaves stage 2
  writeback_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
    writeback.valid |-> $past(dfa_beat.valid && dfa_beat.eop))
    else $error("writeback without an eop beat one cycle earlier");

  // Automaton never runs past a full match
  state_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    dfa_beat.valid |-> (dfa_beat.state <= scan_pkg::dfa_state_t'(scan_pkg::KEYWORD_LEN)))
    else $error("automaton state above the keyword length");

endmodule

bind keyword_scan_top keyword_scan_chk i_keyword_scan_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .apb_req   (apb_req),
  .apb_rsp   (apb_rsp),
  .dfa_beat  (dfa_beat),
  .writeback (writeback),
  .pkt_done  (pkt_done),
  .pkt_hit   (pkt_hit)
);

// ==== test/tb_clock.sv ====
module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 20 time unit period
  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 8;

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  // Reset low for the first cycles, released on a rising edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== logic/keyword_scan_top.sv ====
module keyword_scan_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  scan_pkg::byte_beat_t  beat_in,
  input  scan_pkg::apb_req_t    apb_req,
  output scan_pkg::apb_rsp_t    apb_rsp
);

  // Stage to stage beats
  scan_pkg::ctx_beat_t  ctx_beat;
  scan_pkg::dfa_beat_t  dfa_beat;
  // Loop back into the context memory
  scan_pkg::writeback_t writeback;

  // Packet end events for the counters
  logic pkt_done;
  logic pkt_hit;

  logic [scan_pkg::NUM_STREAMS-1:0] enable_mask;

  // Stage 1, context lookup
  stream_context i_stream_context (
    .clk         (clk),
    .rst_n       (rst_n),
    .beat_in     (beat_in),
    .enable_mask (enable_mask),
    .writeback   (writeback),
    .ctx_out     (ctx_beat)
  );

  // Stage 2, automaton step
  keyword_dfa i_keyword_dfa (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctx_in  (ctx_beat),
    .dfa_out (dfa_beat)
  );

  // Stage 3, per-packet result
  match_accum i_match_accum (
    .clk       (clk),
    .rst_n     (rst_n),
    .dfa_in    (dfa_beat),
    .writeback (writeback),
    .pkt_done  (pkt_done),
    .pkt_hit   (pkt_hit)
  );

  // Configuration and counters
  scan_regs i_scan_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .pkt_done    (pkt_done),
    .pkt_hit     (pkt_hit),
    .enable_mask (enable_mask)
  );

endmodule

// ==== logic/scan_regs.sv ====
module scan_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  scan_pkg::apb_req_t               apb_req,
  output scan_pkg::apb_rsp_t               apb_rsp,
  input  logic                             pkt_done,
  input  logic                             pkt_hit,
  output logic [scan_pkg::NUM_STREAMS-1:0] enable_mask
);

  scan_pkg::count_t hit_count;
  scan_pkg::count_t pkt_count;

  logic access;
  logic wr_en;
  logic addr_ok;

  // Access phase of an APB transfer
  assign access = apb_req.psel && apb_req.penable;
  assign wr_en  = access && apb_req.pwrite;

  always_comb
  begin
    case (apb_req.paddr)
      scan_pkg::REG_ENABLE_LO,
      scan_pkg::REG_ENABLE_HI,
      scan_pkg::REG_HIT_COUNT,
      scan_pkg::REG_PKT_COUNT: addr_ok = 1'b1;
      default:                 addr_ok = 1'b0;
    endcase
  end

  // Read mux
  always_comb
  begin
    case (apb_req.paddr)
      scan_pkg::REG_ENABLE_LO: apb_rsp.prdata = enable_mask[31:0];
      scan_pkg::REG_ENABLE_HI: apb_rsp.prdata = enable_mask[63:32];
      scan_pkg::REG_HIT_COUNT: apb_rsp.prdata = hit_count;
      scan_pkg::REG_PKT_COUNT: apb_rsp.prdata = pkt_count;
      default:                 apb_rsp.prdata = '0;
    endcase
  end

  // No wait states
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && !addr_ok;

  // Enable mask
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      enable_mask <= '0;
    end
    else if (wr_en && apb_req.paddr == scan_pkg::REG_ENABLE_LO)
    begin
      enable_mask[31:0] <= apb_req.pwdata;
    end
    else if (wr_en && apb_req.paddr == scan_pkg::REG_ENABLE_HI)
    begin
      enable_mask[63:32] <= apb_req.pwdata;
    end
  end

  // Counters, a write clears and a same-cycle event still counts
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      hit_count <= '0;
      pkt_count <= '0;
    end
    else
    begin
      if (wr_en && apb_req.paddr == scan_pkg::REG_HIT_COUNT)
      begin
        hit_count <= scan_pkg::count_t'(pkt_hit);
      end
      else if (pkt_hit)
      begin
        hit_count <= hit_count + scan_pkg::count_t'(1);
      end
      if (wr_en && apb_req.paddr == scan_pkg::REG_PKT_COUNT)
      begin
        pkt_count <= scan_pkg::count_t'(pkt_done);
      end
      else if (pkt_done)
      begin
        pkt_count <= pkt_count + scan_pkg::count_t'(1);
      end
    end
  end

endmodule

// ==== logic/match_accum.sv ====
module match_accum (
  input  logic                 clk,
  input  logic                 rst_n,
  input  scan_pkg::dfa_beat_t  dfa_in,
  output scan_pkg::writeback_t writeback,
  output logic                 pkt_done,
  output logic                 pkt_hit
);

  // Keyword seen somewhere in the packet so far
  logic hit_flag;
  logic hit_so_far;
  logic last_beat;

  // Flag starts fresh on sop, then this beat's completion is added
  assign hit_so_far = (hit_flag && !dfa_in.sop) || dfa_in.complete;
  assign last_beat  = dfa_in.valid && dfa_in.eop;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      hit_flag <= 1'b0;
    end
    else if (dfa_in.valid)
    begin
      hit_flag <= hit_so_far;
    end
  end

  // Packet end pulses and state writeback
  always_ff @(posedge clk)
  begin
    writeback.stream_id <= dfa_in.stream_id;
    writeback.state     <= dfa_in.state;
    if (!rst_n)
    begin
      writeback.valid <= 1'b0;
      pkt_done        <= 1'b0;
      pkt_hit         <= 1'b0;
    end
    else
    begin
      // Disabled packets leave the saved state untouched
      writeback.valid <= last_beat && dfa_in.enable;
      // Every packet end is counted
      pkt_done        <= last_beat;
      pkt_hit         <= last_beat && dfa_in.enable && hit_so_far;
    end
  end

endmodule

// ==== logic/keyword_dfa.sv ====
module keyword_dfa (
  input  logic                clk,
  input  logic                rst_n,
  input  scan_pkg::ctx_beat_t ctx_in,
  output scan_pkg::dfa_beat_t dfa_out
);

  // Last state of the packet being scanned
  scan_pkg::dfa_state_t run_state;
  scan_pkg::dfa_state_t cur_state;
  scan_pkg::dfa_state_t nxt_state;
  logic                 nxt_complete;

  // One step of the fixed keyword automaton
  function automatic scan_pkg::dfa_state_t dfa_step(
    input scan_pkg::dfa_state_t cur,
    input scan_pkg::byte_t      ch
  );
    scan_pkg::dfa_state_t eff;
    scan_pkg::byte_t      want;
    scan_pkg::byte_t      first;
    scan_pkg::dfa_state_t res;
    eff = cur;
    // A full match has "t" as its only border
    if (cur >= scan_pkg::dfa_state_t'(scan_pkg::KEYWORD_LEN))
    begin
      eff = 3'd1;
    end
    want  = scan_pkg::KEYWORD[8*(scan_pkg::KEYWORD_LEN-1-int'(eff)) +: 8];
    first = scan_pkg::KEYWORD[8*scan_pkg::KEYWORD_LEN-1 -: 8];
    if (ch == want)
    begin
      res = eff + 3'd1;
    end
    // No prefix of the keyword has a nonempty border short of the full word
    else if (ch == first)
    begin
      res = 3'd1;
    end
    else
    begin
      res = 3'd0;
    end
    return res;
  endfunction

  // sop resumes from the saved state, else continue the running one
  assign cur_state = ctx_in.sop ? ctx_in.start_state : run_state;
  assign nxt_state = dfa_step(cur_state, ctx_in.data);
  assign nxt_complete = (nxt_state == scan_pkg::dfa_state_t'(scan_pkg::KEYWORD_LEN));

  // Running state only moves on valid beats, idle cycles inside a packet hold it
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      run_state <= '0;
    end
    else if (ctx_in.valid)
    begin
      run_state <= nxt_state;
    end
  end

  // Stage 2 register
  always_ff @(posedge clk)
  begin
    dfa_out.sop       <= ctx_in.sop;
    dfa_out.eop       <= ctx_in.eop;
    dfa_out.enable    <= ctx_in.enable;
    dfa_out.stream_id <= ctx_in.stream_id;
    dfa_out.state     <= nxt_state;
    dfa_out.complete  <= nxt_complete;
    if (!rst_n)
    begin
      dfa_out.valid <= 1'b0;
    end
    else
    begin
      dfa_out.valid <= ctx_in.valid;
    end
  end

endmodule

// ==== logic/stream_context.sv ====
module stream_context (
  input  logic                               clk,
  input  logic                               rst_n,
  input  scan_pkg::byte_beat_t               beat_in,
  input  logic [scan_pkg::NUM_STREAMS-1:0]   enable_mask,
  input  scan_pkg::writeback_t               writeback,
  output scan_pkg::ctx_beat_t                ctx_out
);

  // Saved automaton state per stream
  scan_pkg::dfa_state_t state_mem [scan_pkg::NUM_STREAMS];

  // Enable and stream of the packet in progress
  logic                 pkt_enable;
  scan_pkg::stream_id_t pkt_stream;

  // Values seen by the current beat
  logic                 beat_enable;
  scan_pkg::stream_id_t beat_stream;
  scan_pkg::dfa_state_t start_state;

  // On sop take the lookup, afterwards hold what sop found
  always_comb
  begin
    if (beat_in.sop)
    begin
      beat_enable = enable_mask[beat_in.stream_id];
      beat_stream = beat_in.stream_id;
    end
    else
    begin
      beat_enable = pkt_enable;
      beat_stream = pkt_stream;
    end
  end

  // New stream restarts the automaton, else resume where it stopped
  assign start_state = beat_in.new_stream ? '0 : state_mem[beat_in.stream_id];

  // State memory
  // Writeback lands at least one cycle before the next sop of that stream
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < scan_pkg::NUM_STREAMS; i++)
      begin
        state_mem[i] <= '0;
      end
    end
    else if (writeback.valid)
    begin
      state_mem[writeback.stream_id] <= writeback.state;
    end
  end

  // Per-packet context, captured on sop
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pkt_enable <= 1'b0;
      pkt_stream <= '0;
    end
    else if (beat_in.valid && beat_in.sop)
    begin
      pkt_enable <= beat_enable;
      pkt_stream <= beat_stream;
    end
  end

  // Stage 1 register
  always_ff @(posedge clk)
  begin
    // Payload follows the input every cycle
    ctx_out.sop         <= beat_in.sop;
    ctx_out.eop         <= beat_in.eop;
    ctx_out.enable      <= beat_enable;
    ctx_out.stream_id   <= beat_stream;
    ctx_out.data        <= beat_in.data;
    ctx_out.start_state <= start_state;
    if (!rst_n)
    begin
      ctx_out.valid <= 1'b0;
    end
    else
    begin
      ctx_out.valid <= beat_in.valid;
    end
  end

endmodule

// ==== logic/scan_pkg.sv ====
package scan_pkg;

  // Widths that carry a meaning
  typedef logic [7:0]  byte_t;
  typedef logic [5:0]  stream_id_t;
  // 0 is the start, 1..6 is the number of keyword characters matched
  typedef logic [2:0]  dfa_state_t;
  typedef logic [31:0] count_t;
  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  localparam int NUM_STREAMS = 64;
  localparam int KEYWORD_LEN = 6;
  // First character sits in the top byte
  localparam logic [8*KEYWORD_LEN-1:0] KEYWORD = "telnet";

  // APB register offsets
  localparam apb_addr_t REG_ENABLE_LO = 4'h0;
  localparam apb_addr_t REG_ENABLE_HI = 4'h4;
  localparam apb_addr_t REG_HIT_COUNT = 4'h8;
  localparam apb_addr_t REG_PKT_COUNT = 4'hC;

  // Byte input beat, one per cycle, no handshake
  typedef struct packed {
    logic       valid;
    logic       sop;
    logic       eop;
    // Only looked at on sop
    logic       new_stream;
    stream_id_t stream_id;
    byte_t      data;
  } byte_beat_t;

  // Stage 1 output
  typedef struct packed {
    logic       valid;
    logic       sop;
    logic       eop;
    logic       enable;
    stream_id_t stream_id;
    byte_t      data;
    // Meaningful only on sop
    dfa_state_t start_state;
  } ctx_beat_t;

  // Stage 2 output, state is the one after this byte
  typedef struct packed {
    logic       valid;
    logic       sop;
    logic       eop;
    logic       enable;
    stream_id_t stream_id;
    dfa_state_t state;
    logic       complete;
  } dfa_beat_t;

  // Final packet state going back to the context memory
  typedef struct packed {
    logic       valid;
    stream_id_t stream_id;
    dfa_state_t state;
  } writeback_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

endpackage
